/* design/mac_table_pkg.sv */
package mac_table_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////
    localparam int KEY_WIDTH      = 48;
    localparam int TABLE_DEPTH    = 32;
    localparam int INDEX_WIDTH    = 5;
    localparam int COUNT_WIDTH    = 6;
    localparam int AXI_ADDR_WIDTH = 5;
    localparam int AXI_DATA_WIDTH = 32;

    typedef logic [KEY_WIDTH-1:0]      mac_key_t;
    typedef logic [INDEX_WIDTH-1:0]    slot_index_t;
    typedef logic [COUNT_WIDTH-1:0]    entry_count_t;
    typedef logic [AXI_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axil_data_t;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////
    localparam axil_addr_t REG_KEY_LO = 5'h00;
    localparam axil_addr_t REG_KEY_HI = 5'h04;
    localparam axil_addr_t REG_CMD    = 5'h08;
    localparam axil_addr_t REG_STATUS = 5'h0C;
    localparam axil_addr_t REG_COUNT  = 5'h10;

    // STATUS bit positions
    localparam int STAT_BUSY      = 0;
    localparam int STAT_DONE      = 1;
    localparam int STAT_HIT       = 2;
    localparam int STAT_FULL      = 3;
    localparam int STAT_INDEX_LSB = 8;

    // Command codes, low two bits of CMD
    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_LOOKUP = 2'd1,
        OP_LEARN  = 2'd2,
        OP_FLUSH  = 2'd3
    } table_op_t;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_ISSUE, CTRL_WAIT} ctrl_state_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* design/mac_table_ifs.sv */
// Register block to command controller
interface mac_cmd_if;

    import mac_table_pkg::*;

    logic         cmd_start;
    table_op_t    cmd_op;
    mac_key_t     cmd_key;
    logic         busy;
    logic         done;
    logic         hit;
    logic         full;
    slot_index_t  index;
    entry_count_t count;

    modport regs (
        output cmd_start, cmd_op, cmd_key,
        input  busy, done, hit, full, index, count
    );

    modport ctrl (
        input  cmd_start, cmd_op, cmd_key,
        output busy, done, hit, full, index, count
    );

endinterface

// Command controller to table, response one cycle after request
interface cam_req_if;

    import mac_table_pkg::*;

    logic        req_valid;
    table_op_t   req_op;
    mac_key_t    req_key;
    logic        resp_valid;
    logic        resp_hit;
    slot_index_t resp_index;
    logic        resp_full;

    modport requester (
        output req_valid, req_op, req_key,
        input  resp_valid, resp_hit, resp_index, resp_full
    );

    modport responder (
        input  req_valid, req_op, req_key,
        output resp_valid, resp_hit, resp_index, resp_full
    );

endinterface

/* design/cam_table.sv */
module cam_table (
    input  logic         clock,
    input  logic         reset_n,
    cam_req_if.responder cam
);

    import mac_table_pkg::*;

    mac_key_t               keys [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] valid;

    logic                   match_hit;
    slot_index_t            match_index;
    logic                   free_found;
    slot_index_t            free_index;
    logic                   learn_write;
    logic                   flush_req;

    //////////////////////////////////////////////////
    // Parallel compare and free-slot search
    //////////////////////////////////////////////////

    // Walk down so the lowest matching slot wins
    always_comb begin
        match_hit   = 1'b0;
        match_index = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && keys[i] == cam.req_key) begin
                match_hit   = 1'b1;
                match_index = slot_index_t'(i);
            end
        end
    end

    // Lowest slot with its valid bit clear
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_found = 1'b1;
                free_index = slot_index_t'(i);
            end
        end
    end

    assign learn_write = cam.req_valid && cam.req_op == OP_LEARN
                         && !match_hit && free_found;
    assign flush_req   = cam.req_valid && cam.req_op == OP_FLUSH;

    //////////////////////////////////////////////////
    // Table storage
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid <= '0;
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                keys[i] <= '0;
            end
        end else if (flush_req) begin
            valid <= '0;
        end else if (learn_write) begin
            keys[free_index]  <= cam.req_key;
            valid[free_index] <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Result registers
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cam.resp_valid <= 1'b0;
            cam.resp_hit   <= 1'b0;
            cam.resp_index <= '0;
            cam.resp_full  <= 1'b0;
        end else begin
            cam.resp_valid <= cam.req_valid;
            if (cam.req_valid) begin
                // Defaults cover flush and the idle code
                cam.resp_hit   <= 1'b0;
                cam.resp_index <= '0;
                cam.resp_full  <= 1'b0;
                case (cam.req_op)
                    OP_LOOKUP: begin
                        cam.resp_hit   <= match_hit;
                        cam.resp_index <= match_index;
                    end
                    OP_LEARN: begin
                        if (match_hit) begin
                            // Already stored, report existing slot
                            cam.resp_hit   <= 1'b1;
                            cam.resp_index <= match_index;
                        end else if (free_found) begin
                            cam.resp_index <= free_index;
                        end else begin
                            cam.resp_full  <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* design/table_cmd_ctrl.sv */
module table_cmd_ctrl (
    input  logic         clock,
    input  logic         reset_n,
    mac_cmd_if.ctrl      cmd,
    cam_req_if.requester cam
);

    import mac_table_pkg::*;

    ctrl_state_t  state;
    table_op_t    op_q;
    mac_key_t     key_q;
    logic         busy_q;
    logic         done_q;
    logic         hit_q;
    logic         full_q;
    slot_index_t  index_q;
    entry_count_t count_q;
    logic         wrote_entry;

    // A learn that neither found the key nor hit a full table
    assign wrote_entry = op_q == OP_LEARN && !cam.resp_hit && !cam.resp_full;

    //////////////////////////////////////////////////
    // Command FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state   <= CTRL_IDLE;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            hit_q   <= 1'b0;
            full_q  <= 1'b0;
            index_q <= '0;
            count_q <= '0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (cmd.cmd_start) begin
                        state  <= CTRL_ISSUE;
                        busy_q <= 1'b1;
                        done_q <= 1'b0;
                    end
                end
                CTRL_ISSUE: begin
                    state <= CTRL_WAIT;
                end
                CTRL_WAIT: begin
                    if (cam.resp_valid) begin
                        state   <= CTRL_IDLE;
                        busy_q  <= 1'b0;
                        done_q  <= 1'b1;
                        hit_q   <= cam.resp_hit;
                        full_q  <= cam.resp_full;
                        index_q <= cam.resp_index;
                        if (op_q == OP_FLUSH) begin
                            count_q <= '0;
                        end else if (wrote_entry) begin
                            count_q <= count_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // Command capture, starts outside IDLE are ignored
    always_ff @(posedge clock) begin
        if (state == CTRL_IDLE && cmd.cmd_start) begin
            op_q  <= cmd.cmd_op;
            key_q <= cmd.cmd_key;
        end
    end

    assign cam.req_valid = state == CTRL_ISSUE;
    assign cam.req_op    = op_q;
    assign cam.req_key   = key_q;

    assign cmd.busy  = busy_q;
    assign cmd.done  = done_q;
    assign cmd.hit   = hit_q;
    assign cmd.full  = full_q;
    assign cmd.index = index_q;
    assign cmd.count = count_q;

endmodule

/* design/axil_table_regs.sv */
module axil_table_regs (
    input  logic                      clock,
    input  logic                      reset_n,

    input  mac_table_pkg::axil_addr_t awaddr,
    input  logic                      awvalid,
    output logic                      awready,

    input  mac_table_pkg::axil_data_t wdata,
    input  logic                      wvalid,
    output logic                      wready,

    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,

    input  mac_table_pkg::axil_addr_t araddr,
    input  logic                      arvalid,
    output logic                      arready,

    output mac_table_pkg::axil_data_t rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,

    mac_cmd_if.regs                   cmd
);

    import mac_table_pkg::*;

    localparam int KEY_HI_WIDTH = KEY_WIDTH - AXI_DATA_WIDTH;

    logic                    wr_accept;
    logic                    wr_legal;
    logic                    rd_accept;
    axil_data_t              key_lo;
    logic [KEY_HI_WIDTH-1:0] key_hi;
    logic                    start_q;
    table_op_t               op_q;
    axil_data_t              status_word;
    axil_data_t              rd_data;
    logic [1:0]              rd_resp;

    //////////////////////////////////////////////////
    // Write channels
    //////////////////////////////////////////////////

    // Address and data taken together, one response outstanding
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign wr_legal  = awaddr inside {REG_KEY_LO, REG_KEY_HI, REG_CMD};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bvalid  <= 1'b0;
            start_q <= 1'b0;
            key_lo  <= '0;
            key_hi  <= '0;
        end else begin
            start_q <= 1'b0;
            if (wr_accept) begin
                bvalid <= 1'b1;
                case (awaddr)
                    REG_KEY_LO: key_lo  <= wdata;
                    REG_KEY_HI: key_hi  <= wdata[KEY_HI_WIDTH-1:0];
                    REG_CMD:    start_q <= table_op_t'(wdata[1:0]) != OP_NONE;
                    default: begin
                    end
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_accept) begin
            bresp <= wr_legal ? RESP_OKAY : RESP_SLVERR;
            if (awaddr == REG_CMD) begin
                op_q <= table_op_t'(wdata[1:0]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Read channels
    //////////////////////////////////////////////////
    assign arready   = !rvalid;
    assign rd_accept = arvalid && arready;

    always_comb begin
        status_word                                  = '0;
        status_word[STAT_BUSY]                       = cmd.busy;
        status_word[STAT_DONE]                       = cmd.done;
        status_word[STAT_HIT]                        = cmd.hit;
        status_word[STAT_FULL]                       = cmd.full;
        status_word[STAT_INDEX_LSB +: INDEX_WIDTH]   = cmd.index;
    end

    // CMD is write only and reads as an error
    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_KEY_LO: rd_data = key_lo;
            REG_KEY_HI: rd_data = axil_data_t'(key_hi);
            REG_STATUS: rd_data = status_word;
            REG_COUNT:  rd_data = axil_data_t'(cmd.count);
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    assign cmd.cmd_start = start_q;
    assign cmd.cmd_op    = op_q;
    assign cmd.cmd_key   = {key_hi, key_lo};

endmodule

/* design/mac_table_top.sv */
module mac_table_top (
    input  logic                      clock,
    input  logic                      reset_n,

    input  mac_table_pkg::axil_addr_t awaddr,
    input  logic                      awvalid,
    output logic                      awready,

    input  mac_table_pkg::axil_data_t wdata,
    input  logic                      wvalid,
    output logic                      wready,

    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,

    input  mac_table_pkg::axil_addr_t araddr,
    input  logic                      arvalid,
    output logic                      arready,

    output mac_table_pkg::axil_data_t rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    mac_cmd_if cmd_bus ();
    cam_req_if cam_bus ();

    // Bus slave and key registers
    axil_table_regs u_regs (
        .clock   (clock),
        .reset_n (reset_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cmd     (cmd_bus.regs)
    );

    table_cmd_ctrl u_ctrl (
        .clock   (clock),
        .reset_n (reset_n),
        .cmd     (cmd_bus.ctrl),
        .cam     (cam_bus.requester)
    );

    cam_table u_table (
        .clock   (clock),
        .reset_n (reset_n),
        .cam     (cam_bus.responder)
    );

endmodule

/* tb/mac_table_tb.sv */
module mac_table_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mac_table_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int HOLD_CYCLES = 3;

    logic       clock;
    logic       reset_n;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    // Stored keys in slot order
    mac_key_t   model_keys[$];

    mac_table_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_index(input slot_index_t got, input slot_index_t exp,
                               input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input entry_count_t got, input entry_count_t exp,
                               input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_word(input axil_data_t got, input axil_data_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // AXI4-Lite master
    //////////////////////////////////////////////////

    // Waits one more cycle and samples mid-cycle
    task automatic wait_step(inout int waited, input string what);
        if (waited >= WAIT_LIMIT) begin
            stop_run($sformatf("Timed out waiting for %s", what));
        end
        waited++;
        @(negedge clock);
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input int hold, output logic [1:0] resp);
        int waited;
        @(posedge clock);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        do begin
            wait_step(waited, "awready and wready");
        end while (!(awready && wready));
        @(posedge clock);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Address and data are free to change once accepted
        awaddr  = ~addr;
        wdata   = ~data;
        waited  = 0;
        do begin
            wait_step(waited, "bvalid");
        end while (!bvalid);
        resp = bresp;
        // Response must stay put while bready is low
        for (int i = 0; i < hold; i++) begin
            @(negedge clock);
            check_flag(bvalid, 1'b1, "bvalid under back-pressure");
            check_resp(bresp, resp, "bresp under back-pressure");
        end
        @(posedge clock);
        #1;
        bready = 1'b1;
        @(posedge clock);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, input int hold,
                             output axil_data_t data, output logic [1:0] resp);
        int waited;
        @(posedge clock);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        do begin
            wait_step(waited, "arready");
        end while (!arready);
        @(posedge clock);
        #1;
        arvalid = 1'b0;
        araddr  = ~addr;
        waited  = 0;
        do begin
            wait_step(waited, "rvalid");
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clock);
            check_flag(rvalid, 1'b1, "rvalid under back-pressure");
            check_flag(arready, 1'b0, "arready with a read response pending");
            check_word(rdata, data, "rdata under back-pressure");
            check_resp(rresp, resp, "rresp under back-pressure");
        end
        @(posedge clock);
        #1;
        rready = 1'b1;
        @(posedge clock);
        #1;
        rready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Table commands
    //////////////////////////////////////////////////
    task automatic run_command(input table_op_t op, input mac_key_t key,
                               output logic hit, output slot_index_t index,
                               output logic full, output entry_count_t count);
        logic [1:0] resp;
        axil_data_t word;
        int         polls;
        axil_write(REG_KEY_LO, key[31:0], 0, resp);
        check_resp(resp, RESP_OKAY, "KEY_LO write response");
        axil_write(REG_KEY_HI, axil_data_t'(key[KEY_WIDTH-1:32]), 0, resp);
        check_resp(resp, RESP_OKAY, "KEY_HI write response");
        axil_write(REG_CMD, axil_data_t'(op), 0, resp);
        check_resp(resp, RESP_OKAY, "CMD write response");
        polls = 0;
        do begin
            if (polls >= WAIT_LIMIT) begin
                stop_run("Command never reported done in STATUS");
            end
            polls++;
            axil_read(REG_STATUS, 0, word, resp);
            check_resp(resp, RESP_OKAY, "STATUS read response");
        end while (!(word[STAT_DONE] && !word[STAT_BUSY]));
        hit   = word[STAT_HIT];
        full  = word[STAT_FULL];
        index = word[STAT_INDEX_LSB +: INDEX_WIDTH];
        axil_read(REG_COUNT, 0, word, resp);
        check_resp(resp, RESP_OKAY, "COUNT read response");
        count = entry_count_t'(word);
    endtask

    task automatic expect_command(input table_op_t op, input mac_key_t key,
                                  input logic exp_hit, input slot_index_t exp_index,
                                  input logic exp_full, input entry_count_t exp_count);
        logic         hit;
        slot_index_t  index;
        logic         full;
        entry_count_t count;
        run_command(op, key, hit, index, full, count);
        check_flag(hit, exp_hit, $sformatf("%s hit for key %h", op.name(), key));
        check_flag(full, exp_full, $sformatf("%s full for key %h", op.name(), key));
        // Index of a lookup miss carries no meaning
        if (op != OP_LOOKUP || exp_hit) begin
            check_index(index, exp_index, $sformatf("%s index for key %h", op.name(), key));
        end
        check_count(count, exp_count, $sformatf("count after %s", op.name()));
    endtask

    //////////////////////////////////////////////////
    // Directed cases from file
    //////////////////////////////////////////////////
    task automatic run_case_file();
        int              fd;
        int              fields;
        int              line_no;
        logic [1023:0]   text;
        logic [8*8-1:0]  op_name;
        logic [47:0]     first_arg;
        logic [31:0]     f1;
        logic [31:0]     f2;
        logic [31:0]     f3;
        logic [31:0]     f4;
        axil_data_t      data;
        logic [1:0]      resp;
        fd = $fopen("tb/mac_table_cases.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open tb/mac_table_cases.txt");
        end
        line_no = 0;
        while ($fgets(text, fd) > 0) begin
            line_no++;
            op_name = '0;
            fields  = $sscanf(text, "%s %h %h %h %h %h", op_name, first_arg, f1, f2, f3, f4);
            if (fields < 1 || op_name == "#") begin
                continue;
            end
            if (fields < 4) begin
                stop_run($sformatf("Case file line %0d has too few fields", line_no));
            end
            case (op_name)
                "lookup": expect_command(OP_LOOKUP, first_arg, f1[0], slot_index_t'(f2),
                                         f3[0], entry_count_t'(f4));
                "learn":  expect_command(OP_LEARN, first_arg, f1[0], slot_index_t'(f2),
                                         f3[0], entry_count_t'(f4));
                "flush":  expect_command(OP_FLUSH, first_arg, f1[0], slot_index_t'(f2),
                                         f3[0], entry_count_t'(f4));
                "write": begin
                    axil_write(axil_addr_t'(first_arg), f1, HOLD_CYCLES, resp);
                    check_resp(resp, f2[1:0], $sformatf("write response, line %0d", line_no));
                end
                "read": begin
                    axil_read(axil_addr_t'(first_arg), HOLD_CYCLES, data, resp);
                    check_resp(resp, f2[1:0], $sformatf("read response, line %0d", line_no));
                    check_word(data, f1, $sformatf("read data, line %0d", line_no));
                end
                default: begin
                    stop_run($sformatf("Unknown operation on case file line %0d", line_no));
                end
            endcase
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // Random fill to a full table
    //////////////////////////////////////////////////
    function automatic int slot_of(input mac_key_t key);
        for (int i = 0; i < model_keys.size(); i++) begin
            if (model_keys[i] == key) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic mac_key_t random_key();
        return mac_key_t'({$urandom, $urandom});
    endfunction

    task automatic fill_random();
        mac_key_t key;
        int       pick;
        expect_command(OP_FLUSH, '0, 1'b0, '0, 1'b0, '0);
        model_keys.delete();
        while (model_keys.size() < TABLE_DEPTH) begin
            key = random_key();
            if ($urandom % 4 == 0 && model_keys.size() > 0) begin
                // Relearning a stored key keeps its slot
                pick = $urandom % model_keys.size();
                expect_command(OP_LEARN, model_keys[pick], 1'b1, slot_index_t'(pick), 1'b0,
                               entry_count_t'(model_keys.size()));
            end else if (slot_of(key) < 0) begin
                expect_command(OP_LEARN, key, 1'b0, slot_index_t'(model_keys.size()), 1'b0,
                               entry_count_t'(model_keys.size() + 1));
                model_keys.push_back(key);
            end
        end
        do begin
            key = random_key();
        end while (slot_of(key) >= 0);
        expect_command(OP_LEARN, key, 1'b0, '0, 1'b1, entry_count_t'(TABLE_DEPTH));
        expect_command(OP_LOOKUP, key, 1'b0, '0, 1'b0, entry_count_t'(TABLE_DEPTH));
        repeat (8) begin
            pick = $urandom % model_keys.size();
            expect_command(OP_LOOKUP, model_keys[pick], 1'b1, slot_index_t'(pick), 1'b0,
                           entry_count_t'(TABLE_DEPTH));
        end
        expect_command(OP_FLUSH, '0, 1'b0, '0, 1'b0, '0);
        expect_command(OP_LOOKUP, model_keys[0], 1'b0, '0, 1'b0, '0);
        expect_command(OP_LEARN, model_keys[TABLE_DEPTH-1], 1'b0, '0, 1'b0, 6'd1);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(78));
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset_n = 1'b1;
        run_case_file();
        fill_random();
        $display("No errors");
        $finish;
    end

endmodule

/* sources.f */
design/mac_table_pkg.sv
design/mac_table_ifs.sv
design/cam_table.sv
design/table_cmd_ctrl.sv
design/axil_table_regs.sv
design/mac_table_top.sv
tb/mac_table_tb.sv

/* tb/mac_table_cases.txt */
# Command lines: op key hit index full count (all hex)
# Bus lines: read|write offset data resp (hex); read data must match
read   10 00000000 0
learn  0a1b2c3d4e01 0 0 0 1
learn  0a1b2c3d4e02 0 1 0 2
learn  0a1b2c3d4e03 0 2 0 3
lookup 0a1b2c3d4e01 1 0 0 3
lookup 0a1b2c3d4e02 1 1 0 3
lookup 0a1b2c3d4e03 1 2 0 3
lookup 0a1b2c3d4eff 0 0 0 3
learn  0a1b2c3d4e02 1 1 0 3
lookup 0a1b2c3d4e03 1 2 0 3
flush  000000000000 0 0 0 0
lookup 0a1b2c3d4e01 0 0 0 0
learn  0a1b2c3d4e03 0 0 0 1
lookup 0a1b2c3d4e03 1 0 0 1
write  00 deadbeef 0
write  04 0000cafe 0
read   00 deadbeef 0
read   04 0000cafe 0
read   08 00000000 2
read   1c 00000000 2
write  0c 00000001 2
write  10 00000005 2
write  14 00000000 2
read   10 00000001 0
flush  000000000000 0 0 0 0
